// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= decode_stage_tb
FLIST     ?= flist.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

SOURCES := $(shell grep -v '^+' $(FLIST)) $(wildcard hdl/*.svh)
BIN     := $(BUILD_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(BIN): $(SOURCES) $(FLIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FLIST)

run: $(BIN)
	./$(BIN) | tee $(LOG)
	@if grep -q '^SIMULATION PASSED$$' $(LOG); then \
		echo "result: pass"; \
	else \
		echo "result: fail"; exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== bench/decode_stage_sva.sv ====
module decode_stage_sva import decode_pkg::*;
(
        input logic        i_clk,
        input logic        i_reset,
        input pipe_ctl_t   i_ctl,
        input decode_out_t i_decode,
        input exc_t        i_exc
);

timeunit 1ns;
timeprecision 1ps;

// ---------------------------------------------------------------------------
// Stage register checks.
// ---------------------------------------------------------------------------

// Reset and write-back clear leave a bubble.
a_bubble_after_clear: assert property (@(posedge i_clk)
        (i_reset || i_ctl.clear_wb) |=> (i_decode.cond == COND_NV && i_exc == '0))
        else $error("no bubble one cycle after reset or clear_wb");

// Memory stall holds everything.
a_hold_on_data_stall: assert property (@(posedge i_clk)
        (!i_reset && !i_ctl.clear_wb && i_ctl.data_stall) |=> ($stable(i_decode) && $stable(i_exc)))
        else $error("outputs changed during data_stall");

// Lower stalls hold too, when nothing above them is set.
a_hold_on_low_stall: assert property (@(posedge i_clk)
        (!i_reset && i_ctl[4:2] == 3'b000 && (i_ctl.stall_shift || i_ctl.stall_issue))
        |=> ($stable(i_decode) && $stable(i_exc)))
        else $error("outputs changed during stall_shift or stall_issue");

endmodule

bind decode_stage_reg decode_stage_sva u_decode_stage_sva (
        .i_clk    (i_clk),
        .i_reset  (i_reset),
        .i_ctl    (i_ctl),
        .i_decode (o_decode),
        .i_exc    (o_exc)
);

// ==== bench/decode_stage_tb.sv ====
`include "decode_consts.svh"

module decode_stage_tb
        import decode_pkg::*;
();

timeunit 1ns;
timeprecision 1ps;

// Five tests, then some slack for reset and the drain.
localparam int TEST_CYCLES    = 400;
localparam int NUM_TESTS      = 5;
localparam int TIMEOUT_CYCLES = NUM_TESTS * TEST_CYCLES + 200;

logic        clk;
logic        reset;
logic [31:0] instruction;
logic        instruction_valid;
cpu_mode_t   mode;
logic        cpsr_i;
logic        cpsr_f;
logic        irq;
logic        fiq;
logic        abt;
pipe_ctl_t   ctl;
decode_out_t dut_decode;
exc_t        dut_exc;

// Model state, one cycle behind the inputs.
decode_out_t exp_decode;
exc_t        exp_exc;
logic        fields_known;
int          errors;
int          checks;
int          cycle_count;

cpu_mode_t modes [7] = '{MODE_USR, MODE_FIQ, MODE_IRQ, MODE_SVC,
                         MODE_ABT, MODE_UND, MODE_SYS};

decode_stage u_decode_stage (
        .i_clk               (clk),
        .i_reset             (reset),
        .i_instruction       (instruction),
        .i_instruction_valid (instruction_valid),
        .i_mode              (mode),
        .i_cpsr_i            (cpsr_i),
        .i_cpsr_f            (cpsr_f),
        .i_irq               (irq),
        .i_fiq               (fiq),
        .i_abt               (abt),
        .i_ctl               (ctl),
        .o_decode            (dut_decode),
        .o_exc               (dut_exc)
);

initial
        clk = 1'b0;

always #10 clk = ~clk;

// ---------------------------------------------------------------------------
// Reference model.
// ---------------------------------------------------------------------------

// Banked register file layout.
function automatic phys_idx_t bank_reg(input logic [3:0] r, input cpu_mode_t m);
        phys_idx_t p;
        p = {1'b0, r};
        if (m == MODE_FIQ && r >= 4'd8 && r != 4'd15)
                return `PHYS_FIQ_BASE + p - 5'd8;
        if (r != 4'd13 && r != 4'd14)
                return p;
        case (m)
        MODE_IRQ: return `PHYS_IRQ_BASE + p - 5'd13;
        MODE_SVC: return `PHYS_SVC_BASE + p - 5'd13;
        MODE_ABT: return `PHYS_ABT_BASE + p - 5'd13;
        MODE_UND: return `PHYS_UND_BASE + p - 5'd13;
        default:  return p;
        endcase
endfunction

function automatic operand_t reg_operand(input logic [3:0] r, input cpu_mode_t m);
        return {1'b0, 27'd0, bank_reg(r, m)};
endfunction

function automatic operand_t const_operand(input logic [31:0] v);
        return {1'b1, v};
endfunction

// Whole decode and map of one word.
task automatic predict_decode(input logic [31:0] w, input logic valid, input cpu_mode_t m,
                              output decode_out_t d, output logic swi, output logic und);
        d             = '0;
        d.dest        = `PHYS_DISCARD;
        d.mem_srcdest = `PHYS_DISCARD;
        d.cond        = cond_t'(w[31:28]);
        swi           = 1'b0;
        und           = 1'b0;
        if (w[27:24] == 4'hf)
                swi = 1'b1;
        else if (w[27:26] == 2'b00)
        begin
                d.alu_op      = alu_op_t'(w[24:21]);
                d.flag_update = w[20];
                d.alu_src     = reg_operand(w[19:16], m);
                // Compare ops 8 to 11 have no result.
                if (w[24:21] < 4'h8 || w[24:21] > 4'hb)
                        d.dest = bank_reg(w[15:12], m);
                if (w[25])
                begin
                        d.shift_src = const_operand(32'(w[7:0]));
                        d.shift_op  = SH_ROR;
                        d.shift_len = const_operand(32'(w[11:8]) * 32'd2);
                end
                else
                begin
                        d.shift_src = reg_operand(w[3:0], m);
                        d.shift_op  = shift_op_t'(w[6:5]);
                        if (!w[4])
                                d.shift_len = const_operand(32'(w[11:7]));
                        else if (!w[7])
                                d.shift_len = reg_operand(w[11:8], m);
                        else
                                und = 1'b1;
                end
        end
        else if (w[27:26] == 2'b01)
        begin
                d.alu_op      = w[23] ? ALU_ADD : ALU_SUB;
                d.alu_src     = reg_operand(w[19:16], m);
                d.shift_src   = w[25] ? reg_operand(w[3:0], m) : const_operand(32'(w[11:0]));
                d.shift_op    = w[25] ? shift_op_t'(w[6:5]) : SH_LSL;
                d.shift_len   = const_operand(w[25] ? 32'(w[11:7]) : 32'd0);
                und           = w[25] & w[4];
                d.mem_srcdest = bank_reg(w[15:12], m);
                // Load, store, pre_index, unsigned_byte, translate.
                d.mem = {w[20], ~w[20], w[24], w[22], ~w[24] & w[21]};
                // Writeback of the base.
                if (!w[24] || w[21])
                        d.dest = bank_reg(w[19:16], m);
        end
        else
                und = 1'b1;
        if (!valid)
        begin
                d.cond = COND_NV;
                swi    = 1'b0;
                und    = 1'b0;
        end
endtask

// Priority of clears and stalls at one rising edge.
task automatic apply_edge(input decode_out_t d, input exc_t e);
        if (reset || ctl.clear_wb || (!ctl.data_stall && ctl.clear_alu))
        begin
                exp_decode.cond = COND_NV;
                exp_exc         = '0;
        end
        else if (!ctl.data_stall && !ctl.stall_shift && !ctl.stall_issue)
        begin
                exp_decode   = d;
                exp_exc      = e;
                fields_known = 1'b1;
        end
endtask

// ---------------------------------------------------------------------------
// Compare tasks.
// ---------------------------------------------------------------------------

task automatic compare_cond(input cond_t got, input cond_t want);
        checks++;
        if (got !== want)
        begin
                errors++;
                $display("mismatch at %0t: cond got %h expected %h", $time, got, want);
        end
endtask

task automatic compare_decode(input decode_out_t got, input decode_out_t want);
        checks++;
        if (got !== want)
        begin
                errors++;
                $display("mismatch at %0t: decode got %h expected %h", $time, got, want);
        end
endtask

task automatic compare_exc(input exc_t got, input exc_t want);
        checks++;
        if (got !== want)
        begin
                errors++;
                $display("mismatch at %0t: exceptions got %b expected %b", $time, got, want);
        end
endtask

// ---------------------------------------------------------------------------
// Stimulus.
// ---------------------------------------------------------------------------

// Form 0 rotated imm, 1 imm shift, 2 register shift.
function automatic logic [31:0] dp_word(input logic [31:0] r, input int form);
        logic [31:0] w;
        w        = r;
        w[27:26] = 2'b00;
        w[25]    = (form == 0);
        if (form == 1)
                w[4] = 1'b0;
        if (form == 2)
        begin
                w[4] = 1'b1;
                w[7] = 1'b0;
        end
        return w;
endfunction

function automatic logic [31:0] ls_word(input logic [31:0] r);
        logic [31:0] w;
        w        = r;
        w[27:26] = 2'b01;
        return w;
endfunction

// Any class, the undefined ones too.
function automatic logic [31:0] any_word(input logic [31:0] r, input int kind);
        logic [31:0] w;
        w = r;
        case (kind)
        0: w = dp_word(r, int'($urandom_range(0, 2)));
        1: w = ls_word(r);
        2: w[27:24] = 4'hf;
        3: w[27:26] = 2'b10;
        4: w[27:24] = 4'hc;
        default:
        begin
                // Multiply space.
                w[27:25] = 3'b000;
                w[7]     = 1'b1;
                w[4]     = 1'b1;
        end
        endcase
        return w;
endfunction

function automatic cpu_mode_t random_mode();
        logic [2:0] k;
        k = 3'($urandom_range(0, 6));
        return modes[k];
endfunction

// Inputs are already set, half a cycle before the edge.
task automatic run_cycle();
        decode_out_t d;
        exc_t        e;
        logic        swi;
        logic        und;
        predict_decode(instruction, instruction_valid, mode, d, swi, und);
        e.irq = irq & ~cpsr_i;
        e.fiq = fiq & ~cpsr_f;
        e.abt = abt & instruction_valid;
        e.und = und;
        e.swi = swi;
        @(posedge clk);
        apply_edge(d, e);
        @(negedge clk);
        if (fields_known)
                compare_decode(dut_decode, exp_decode);
        else
                compare_cond(dut_decode.cond, exp_decode.cond);
        compare_exc(dut_exc, exp_exc);
endtask

task automatic run_test(input int num, input string name);
        int          first_errors;
        logic [31:0] r;
        logic [31:0] s;
        first_errors = errors;
        // Reset test starts with the reset itself.
        if (num == 1)
        begin
                reset = 1'b1;
                repeat (2) run_cycle();
                reset = 1'b0;
        end
        for (int n = 0; n < TEST_CYCLES; n++)
        begin
                r                 = $urandom();
                s                 = $urandom();
                instruction_valid = 1'b1;
                mode              = MODE_USR;
                {irq, fiq, abt, cpsr_i, cpsr_f} = 5'b00011;
                ctl               = '0;
                case (num)
                1:
                begin
                        instruction       = r;
                        instruction_valid = 1'b0;
                        mode              = random_mode();
                end
                2: instruction = dp_word(r, int'($urandom_range(0, 2)));
                3: instruction = ls_word(r);
                4:
                begin
                        instruction       = any_word(r, int'($urandom_range(0, 5)));
                        mode              = random_mode();
                        instruction_valid = (s[2:0] != 3'd0);
                end
                default:
                begin
                        instruction       = any_word(r, int'($urandom_range(0, 5)));
                        mode              = random_mode();
                        instruction_valid = s[15] | s[16];
                        {irq, fiq, abt, cpsr_i, cpsr_f} = s[4:0];
                        // Each clear or stall about one cycle in four.
                        ctl = s[9:5] & s[14:10];
                end
                endcase
                run_cycle();
        end
        $display("test %0d %s finished with %0d errors", num, name, errors - first_errors);
endtask

// ---------------------------------------------------------------------------
// Run.
// ---------------------------------------------------------------------------

initial
begin
        void'($urandom(32'ha2d71d48));
        reset             = 1'b1;
        instruction       = '0;
        instruction_valid = 1'b0;
        mode              = MODE_USR;
        cpsr_i            = 1'b1;
        cpsr_f            = 1'b1;
        irq               = 1'b0;
        fiq               = 1'b0;
        abt               = 1'b0;
        ctl               = '0;
        exp_decode        = '0;
        exp_exc           = '0;
        fields_known      = 1'b0;
        errors            = 0;
        checks            = 0;

        run_test(1, "reset and idle");
        run_test(2, "data processing");
        run_test(3, "load store");
        run_test(4, "modes and classes");
        run_test(5, "exceptions clears stalls");

        $display("%0d checks, %0d errors", checks, errors);
        if (errors == 0)
                $display("SIMULATION PASSED");
        else
                $display("SIMULATION FAILED");
        $finish;
end

// Guard against a stuck run.
initial
begin
        cycle_count = 0;
        while (cycle_count < TIMEOUT_CYCLES)
        begin
                @(posedge clk);
                cycle_count++;
        end
        $display("timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
        $display("SIMULATION FAILED");
        $finish;
end

endmodule

// ==== flist.f ====
+incdir+hdl
hdl/decode_pkg.sv
hdl/arm_field_decoder.sv
hdl/bank_index_map.sv
hdl/decode_stage_reg.sv
hdl/decode_stage.sv
bench/decode_stage_sva.sv
bench/decode_stage_tb.sv

// ==== hdl/arm_field_decoder.sv ====
`include "decode_consts.svh"

module arm_field_decoder import decode_pkg::*;
(
        input  logic [31:0]  i_instruction,
        input  logic         i_instruction_valid,
        output arch_decode_t o_arch
);

// ---------------------------------------------------------------------------
// Register fields of the instruction word.
// ---------------------------------------------------------------------------

logic [`ARCH_REG_W-1:0] rn;
logic [`ARCH_REG_W-1:0] rd;
logic [`ARCH_REG_W-1:0] rs;
logic [`ARCH_REG_W-1:0] rm;

assign rn = i_instruction[19:16];
assign rd = i_instruction[15:12];
assign rs = i_instruction[11:8];
assign rm = i_instruction[3:0];

// Enabled register reference.
function automatic arch_ref_t reg_ref(input logic [`ARCH_REG_W-1:0] idx);
        reg_ref.en  = 1'b1;
        reg_ref.idx = idx;
endfunction

// Register operand, index in the low bits.
function automatic arch_operand_t reg_opnd(input logic [`ARCH_REG_W-1:0] idx);
        reg_opnd.imm   = 1'b0;
        reg_opnd.value = {28'd0, idx};
endfunction

function automatic arch_operand_t imm_opnd(input logic [31:0] value);
        imm_opnd.imm   = 1'b1;
        imm_opnd.value = value;
endfunction

// ---------------------------------------------------------------------------
// Class decode.
// ---------------------------------------------------------------------------

always_comb
begin
        // Unused fields stay zero, destinations disabled.
        o_arch      = '0;
        o_arch.cond = cond_t'(i_instruction[31:28]);

        if (&i_instruction[27:24])
        begin
                // SWI. Execute decides whether it is taken.
                o_arch.swi = 1'b1;
        end
        else if (i_instruction[27:26] == 2'b00)
        begin
                // Data processing.
                o_arch.alu_op      = alu_op_t'(i_instruction[24:21]);
                o_arch.flag_update = i_instruction[20];
                o_arch.alu_src     = reg_opnd(rn);

                // TST, TEQ, CMP, CMN write flags only.
                if (i_instruction[24:23] != 2'b10)
                        o_arch.dest = reg_ref(rd);

                if (i_instruction[25])
                begin
                        // imm8 rotated right by twice rot4.
                        o_arch.shift_src = imm_opnd({24'd0, i_instruction[7:0]});
                        o_arch.shift_op  = SH_ROR;
                        o_arch.shift_len = imm_opnd({27'd0, i_instruction[11:8], 1'b0});
                end
                else
                begin
                        o_arch.shift_src = reg_opnd(rm);
                        o_arch.shift_op  = shift_op_t'(i_instruction[6:5]);

                        if (!i_instruction[4])
                                o_arch.shift_len = imm_opnd({27'd0, i_instruction[11:7]});
                        else if (!i_instruction[7])
                                o_arch.shift_len = reg_opnd(rs);
                        else
                                // Multiply and halfword space.
                                o_arch.und = 1'b1;
                end
        end
        else if (i_instruction[27:26] == 2'b01)
        begin
                // Load/store. ALU forms the address from Rn.
                o_arch.alu_op  = i_instruction[23] ? ALU_ADD : ALU_SUB;
                o_arch.alu_src = reg_opnd(rn);

                if (!i_instruction[25])
                begin
                        // 12-bit offset, no shift.
                        o_arch.shift_src = imm_opnd({20'd0, i_instruction[11:0]});
                        o_arch.shift_op  = SH_LSL;
                        o_arch.shift_len = imm_opnd(32'd0);
                end
                else
                begin
                        o_arch.shift_src = reg_opnd(rm);
                        o_arch.shift_op  = shift_op_t'(i_instruction[6:5]);
                        o_arch.shift_len = imm_opnd({27'd0, i_instruction[11:7]});
                        // Register shift amount is not allowed here.
                        o_arch.und       = i_instruction[4];
                end

                o_arch.mem_srcdest       = reg_ref(rd);
                o_arch.mem.load          = i_instruction[20];
                o_arch.mem.store         = !i_instruction[20];
                o_arch.mem.pre_index     = i_instruction[24];
                o_arch.mem.unsigned_byte = i_instruction[22];

                // Post-indexed with W set forces a user view.
                o_arch.mem.translate = !i_instruction[24] && i_instruction[21];

                // Base writeback.
                if (!i_instruction[24] || i_instruction[21])
                        o_arch.dest = reg_ref(rn);
        end
        else
        begin
                // Branch, block transfer, coprocessor.
                o_arch.und = 1'b1;
        end

        // No instruction. Bubble condition, no exceptions.
        if (!i_instruction_valid)
        begin
                o_arch.cond = COND_NV;
                o_arch.swi  = 1'b0;
                o_arch.und  = 1'b0;
        end
end

endmodule

// ==== hdl/bank_index_map.sv ====
`include "decode_consts.svh"

module bank_index_map import decode_pkg::*;
(
        input  arch_decode_t i_arch,
        input  cpu_mode_t    i_mode,
        output decode_out_t  o_decode
);

// ---------------------------------------------------------------------------
// Banking rule.
// ---------------------------------------------------------------------------

// r0 to r7 and r15 are never banked.
function automatic phys_idx_t map_reg(input logic [`ARCH_REG_W-1:0] idx,
                                      input cpu_mode_t mode);
        phys_idx_t arch;
        arch    = {1'b0, idx};
        map_reg = arch;
        if (mode == MODE_FIQ && idx >= 4'd8 && idx <= 4'd14)
                map_reg = `PHYS_FIQ_BASE + (arch - 5'd8);
        else if (idx == 4'd13 || idx == 4'd14)
        begin
                // Only sp and lr are banked here.
                case (mode)
                MODE_IRQ: map_reg = `PHYS_IRQ_BASE + (arch - 5'd13);
                MODE_SVC: map_reg = `PHYS_SVC_BASE + (arch - 5'd13);
                MODE_ABT: map_reg = `PHYS_ABT_BASE + (arch - 5'd13);
                MODE_UND: map_reg = `PHYS_UND_BASE + (arch - 5'd13);
                default:  map_reg = arch;
                endcase
        end
endfunction

// Disabled reference goes nowhere.
function automatic phys_idx_t map_ref(input arch_ref_t ref_in, input cpu_mode_t mode);
        map_ref = ref_in.en ? map_reg(ref_in.idx, mode) : `PHYS_DISCARD;
endfunction

// Constants pass through untouched.
function automatic operand_t map_opnd(input arch_operand_t op, input cpu_mode_t mode);
        map_opnd.imm = op.imm;
        if (op.imm)
                map_opnd.value = op.value;
        else
                map_opnd.value = {27'd0, map_reg(op.value[`ARCH_REG_W-1:0], mode)};
endfunction

// ---------------------------------------------------------------------------
// Field mapping.
// ---------------------------------------------------------------------------

always_comb
begin
        o_decode.cond        = i_arch.cond;
        o_decode.alu_op      = i_arch.alu_op;
        o_decode.flag_update = i_arch.flag_update;
        o_decode.dest        = map_ref(i_arch.dest, i_mode);
        o_decode.mem_srcdest = map_ref(i_arch.mem_srcdest, i_mode);
        o_decode.alu_src     = map_opnd(i_arch.alu_src, i_mode);
        o_decode.shift_src   = map_opnd(i_arch.shift_src, i_mode);
        o_decode.shift_len   = map_opnd(i_arch.shift_len, i_mode);
        o_decode.shift_op    = i_arch.shift_op;
        o_decode.mem         = i_arch.mem;
end

endmodule

// ==== hdl/decode_consts.svh ====
`ifndef DECODE_CONSTS_SVH
`define DECODE_CONSTS_SVH

// ---------------------------------------------------------------------------
// Register index widths.
// ---------------------------------------------------------------------------

// Architectural index, r0 to r15.
`define ARCH_REG_W      4

// Physical index into the banked register file.
`define PHYS_REG_W      5

// ---------------------------------------------------------------------------
// Physical register file layout.
// ---------------------------------------------------------------------------

// No register. A result sent here is thrown away.
`define PHYS_DISCARD    5'd31

// FIQ banks r8 to r14, seven entries.
`define PHYS_FIQ_BASE   5'd16

// Other exception modes bank only r13 and r14.
`define PHYS_IRQ_BASE   5'd23
`define PHYS_SVC_BASE   5'd25
`define PHYS_ABT_BASE   5'd27
`define PHYS_UND_BASE   5'd29

`endif

// ==== hdl/decode_pkg.sv ====
`include "decode_consts.svh"

package decode_pkg;

        // -------------------------------------------------------------------
        // Encodings.
        // -------------------------------------------------------------------

        // ARM condition field. NV marks a bubble in the pipe.
        typedef enum logic [3:0] {
                COND_EQ, COND_NE, COND_CS, COND_CC,
                COND_MI, COND_PL, COND_VS, COND_VC,
                COND_HI, COND_LS, COND_GE, COND_LT,
                COND_GT, COND_LE, COND_AL, COND_NV
        } cond_t;

        // Data processing opcodes, in encoding order.
        typedef enum logic [3:0] {
                ALU_AND, ALU_EOR, ALU_SUB, ALU_RSB,
                ALU_ADD, ALU_ADC, ALU_SBC, ALU_RSC,
                ALU_TST, ALU_TEQ, ALU_CMP, ALU_CMN,
                ALU_ORR, ALU_MOV, ALU_BIC, ALU_MVN
        } alu_op_t;

        // Barrel shifter operations.
        typedef enum logic [1:0] {
                SH_LSL, SH_LSR, SH_ASR, SH_ROR
        } shift_op_t;

        // CPSR mode field.
        typedef enum logic [4:0] {
                MODE_USR = 5'h10,
                MODE_FIQ = 5'h11,
                MODE_IRQ = 5'h12,
                MODE_SVC = 5'h13,
                MODE_ABT = 5'h17,
                MODE_UND = 5'h1b,
                MODE_SYS = 5'h1f
        } cpu_mode_t;

        // -------------------------------------------------------------------
        // Register references and operands.
        // -------------------------------------------------------------------

        typedef logic [`PHYS_REG_W-1:0] phys_idx_t;

        // Enable clear means no register.
        typedef struct packed {
                logic                   en;
                logic [`ARCH_REG_W-1:0] idx;
        } arch_ref_t;

        // Flag clear: low 4 bits are an architectural index.
        typedef struct packed {
                logic        imm;
                logic [31:0] value;
        } arch_operand_t;

        // Flag clear: low 5 bits are a physical index.
        typedef struct packed {
                logic        imm;
                logic [31:0] value;
        } operand_t;

        // Word and unsigned byte transfers only.
        typedef struct packed {
                logic load;
                logic store;
                logic pre_index;
                logic unsigned_byte;
                logic translate;
        } mem_ctl_t;

        // -------------------------------------------------------------------
        // Stage bundles.
        // -------------------------------------------------------------------

        // Decoder output, architectural indices.
        typedef struct packed {
                cond_t         cond;
                alu_op_t       alu_op;
                logic          flag_update;
                arch_ref_t     dest;
                arch_ref_t     mem_srcdest;
                arch_operand_t alu_src;
                arch_operand_t shift_src;
                arch_operand_t shift_len;
                shift_op_t     shift_op;
                mem_ctl_t      mem;
                logic          swi;
                logic          und;
        } arch_decode_t;

        // Same fields after bank mapping.
        typedef struct packed {
                cond_t     cond;
                alu_op_t   alu_op;
                logic      flag_update;
                phys_idx_t dest;
                phys_idx_t mem_srcdest;
                operand_t  alu_src;
                operand_t  shift_src;
                operand_t  shift_len;
                shift_op_t shift_op;
                mem_ctl_t  mem;
        } decode_out_t;

        typedef struct packed {
                logic irq;
                logic fiq;
                logic abt;
                logic und;
                logic swi;
        } exc_t;

        // Highest priority first.
        typedef struct packed {
                logic clear_wb;
                logic data_stall;
                logic clear_alu;
                logic stall_shift;
                logic stall_issue;
        } pipe_ctl_t;

endpackage

// ==== hdl/decode_stage.sv ====
module decode_stage import decode_pkg::*;
(
        input  logic        i_clk,
        input  logic        i_reset,

        input  logic [31:0] i_instruction,
        input  logic        i_instruction_valid,

        // From CPSR.
        input  cpu_mode_t   i_mode,
        input  logic        i_cpsr_i,
        input  logic        i_cpsr_f,

        input  logic        i_irq,
        input  logic        i_fiq,
        input  logic        i_abt,

        input  pipe_ctl_t   i_ctl,

        output decode_out_t o_decode,
        output exc_t        o_exc
);

arch_decode_t arch;
decode_out_t  mapped;

// Fields, architectural indices.
arm_field_decoder u_arm_field_decoder (
        .i_instruction       (i_instruction),
        .i_instruction_valid (i_instruction_valid),
        .o_arch              (arch)
);

// Physical indices for the current mode.
bank_index_map u_bank_index_map (
        .i_arch   (arch),
        .i_mode   (i_mode),
        .o_decode (mapped)
);

// One cycle of latency.
decode_stage_reg u_decode_stage_reg (
        .i_clk    (i_clk),
        .i_reset  (i_reset),
        .i_ctl    (i_ctl),
        .i_decode (mapped),
        .i_swi    (arch.swi),
        .i_und    (arch.und),
        .i_valid  (i_instruction_valid),
        .i_irq    (i_irq),
        .i_fiq    (i_fiq),
        .i_abt    (i_abt),
        .i_cpsr_i (i_cpsr_i),
        .i_cpsr_f (i_cpsr_f),
        .o_decode (o_decode),
        .o_exc    (o_exc)
);

endmodule

// ==== hdl/decode_stage_reg.sv ====
module decode_stage_reg import decode_pkg::*;
(
        input  logic        i_clk,
        input  logic        i_reset,

        // Clears and stalls, plain levels.
        input  pipe_ctl_t   i_ctl,

        input  decode_out_t i_decode,
        input  logic        i_swi,
        input  logic        i_und,
        input  logic        i_valid,

        // Raw events and CPSR masks.
        input  logic        i_irq,
        input  logic        i_fiq,
        input  logic        i_abt,
        input  logic        i_cpsr_i,
        input  logic        i_cpsr_f,

        output decode_out_t o_decode,
        output exc_t        o_exc
);

// ---------------------------------------------------------------------------
// Next exception flags.
// ---------------------------------------------------------------------------

exc_t exc_nxt;

always_comb
begin
        // Interrupts pass only when unmasked.
        exc_nxt.irq = i_irq & ~i_cpsr_i;
        exc_nxt.fiq = i_fiq & ~i_cpsr_f;
        // Abort belongs to a fetched instruction.
        exc_nxt.abt = i_abt & i_valid;
        exc_nxt.und = i_und;
        exc_nxt.swi = i_swi;
end

// ---------------------------------------------------------------------------
// Stage register.
// ---------------------------------------------------------------------------

// Bubble touches only the condition and the flags.
always_ff @(posedge i_clk)
begin
        if (i_reset || i_ctl.clear_wb)
        begin
                o_decode.cond <= COND_NV;
                o_exc         <= '0;
        end
        else if (i_ctl.data_stall)
        begin
                // Hold. Memory is not ready.
        end
        else if (i_ctl.clear_alu)
        begin
                // Branch resolved in execute.
                o_decode.cond <= COND_NV;
                o_exc         <= '0;
        end
        else if (i_ctl.stall_shift || i_ctl.stall_issue)
        begin
                // Hold for shifter or issue.
        end
        else
        begin
                o_decode <= i_decode;
                o_exc    <= exc_nxt;
        end
end

endmodule
